/* flist.f */
hdl/minimig_io_pkg.sv
hdl/amiga_clk_en.sv
hdl/user_io.sv
hdl/kbd_mouse_port.sv
hdl/minimig_io_top.sv
bench/minimig_io_properties.sv
bench/minimig_io_tb.sv

/* run.sh */
#!/bin/sh
# build and run the minimig io testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert -Wno-fatal --top-module minimig_io_tb -f flist.f -o sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* bench/minimig_io_tb.sv */
`timescale 1ns/10ps
// testbench for the minimig io slice
// random control processor frames over spi, checked against a reference model
module minimig_io_tb;

  import minimig_io_pkg::*;

  localparam spi_byte_t   CORE_ID    = 8'hA1;
  localparam int          KEY_DEPTH  = 4;
  localparam int          FRAME_MAX  = KEY_DEPTH + 4;  // cmd, type, codes past full
  localparam int          NUM_FRAMES = 60;
  localparam int          MAX_CYCLES = 200000;  // 60 frames x 4 bytes x 64 cycles, x10
  localparam int          SCK_HALF   = 4;       // clk_28 cycles per sck level
  localparam int          SETTLE     = 8;       // worst latency to a visible output
  localparam logic [31:0] SEED       = 32'h2416_5383;

  logic       clk_28;
  logic       reset;
  logic       SPI_SCK;
  logic       SPI_DI;
  logic       CONF_DATA0;
  logic       SPI_SS2;
  logic       SPI_SS3;
  logic       SPI_DO;
  joy_t       joya;
  joy_t       joyb;
  logic [2:0] mouse_buttons;
  mouse_dat_t mouse_dat;
  spi_byte_t  key_code;
  logic       key_valid;
  logic       key_ack;
  logic       clk7_en;
  logic       cck;
  eclk_t      eclk;

  // reference model
  joy_t       exp_joya;
  joy_t       exp_joyb;
  logic [2:0] exp_buttons;
  mouse_cnt_t exp_mouse_x;
  mouse_cnt_t exp_mouse_y;
  spi_byte_t  key_model [$];     // fifo contents, oldest first
  spi_byte_t  popped_code;

  spi_byte_t  frame_buf [FRAME_MAX];
  int         frame_len;
  spi_byte_t  id_bits;          // SPI_DO during the command byte
  int         cycles;

  minimig_io_top #(
    .CORE_TYPE      (CORE_ID),
    .KEY_FIFO_DEPTH (KEY_DEPTH)
  ) dut_i (
    .clk_28        (clk_28),
    .reset         (reset),
    .SPI_SCK       (SPI_SCK),
    .SPI_DI        (SPI_DI),
    .CONF_DATA0    (CONF_DATA0),
    .SPI_SS2       (SPI_SS2),
    .SPI_SS3       (SPI_SS3),
    .SPI_DO        (SPI_DO),
    .joya          (joya),
    .joyb          (joyb),
    .mouse_buttons (mouse_buttons),
    .mouse_dat     (mouse_dat),
    .key_code      (key_code),
    .key_valid     (key_valid),
    .key_ack       (key_ack),
    .clk7_en       (clk7_en),
    .cck           (cck),
    .eclk          (eclk)
  );

  always #50 clk_28 = ~clk_28;  // 100 ns period

  ////////////////////////////////////////////////////////////
  // watchdog and key pop monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk_28) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
    end
  end

  always @(posedge clk_28) begin
    if (!reset && key_valid && key_ack) begin  // one pop this edge
      compare("key_valid", 32'(key_valid), 32'(key_model.size() != 0));
      popped_code = key_model.pop_front();
      compare("key_code", 32'(key_code), 32'(popped_code));
    end
  end

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  // phase counter starts at 0 after reset, so clk7_en on every 4th sample
  task automatic clock_enable_test();
    int i;
    int n_en;
    int e9_count;
    n_en     = 0;
    e9_count = 0;
    for (i = 0; i < 100; i++) begin
      @(posedge clk_28);
      compare("clk7_en", 32'(clk7_en), 32'((i % 4) == 3));
      compare("cck", 32'(cck), 32'(n_en % 2));          // one toggle per enable
      compare("eclk", 32'(eclk), 32'(1) << (n_en % 10)); // ring step per enable
      if (i >= 40 && i < 80 && eclk[9]) e9_count++;
      if (clk7_en) n_en++;
    end
    compare("eclk[9] cycles in 40", 32'(e9_count), 32'(4));
  endtask

  // mode 0, msb first, frame_buf[0 .. frame_len-1]
  task automatic send_frame();
    int b;
    int i;
    CONF_DATA0 <= 1'b0;
    for (b = 0; b < frame_len; b++) begin
      for (i = 7; i >= 0; i--) begin
        SPI_SCK <= 1'b0;
        SPI_DI  <= frame_buf[b][i];
        repeat (SCK_HALF) @(posedge clk_28);
        SPI_SCK <= 1'b1;
        if (b == 0) id_bits[i] = SPI_DO;  // settled during the low phase
        repeat (SCK_HALF) @(posedge clk_28);
      end
    end
    SPI_SCK <= 1'b0;
    repeat (SCK_HALF) @(posedge clk_28);
    CONF_DATA0 <= 1'b1;
    repeat (SCK_HALF) @(posedge clk_28);
    compare("core id on SPI_DO", 32'(id_bits), 32'(CORE_ID));
  endtask

  task automatic check_outputs();
    repeat (SETTLE) @(posedge clk_28);
    compare("joya", 32'(joya), 32'(exp_joya));
    compare("joyb", 32'(joyb), 32'(exp_joyb));
    compare("mouse_buttons", 32'(mouse_buttons), 32'(exp_buttons));
    compare("mouse_dat", 32'(mouse_dat), 32'({exp_mouse_y, exp_mouse_x}));
  endtask

  // called with key_ack low, so the model sees the same fill level
  task automatic queue_keys(input int first);
    int i;
    for (i = first; i < frame_len; i++) begin
      if (key_model.size() < KEY_DEPTH) key_model.push_back(frame_buf[i]);  // else dropped
    end
  endtask

  task automatic ack_stretch();
    int len;
    int i;
    len = $urandom_range(0, 40);
    for (i = 0; i < len; i++) begin
      key_ack <= ($urandom_range(0, 1) == 1);
      @(posedge clk_28);
    end
    key_ack <= 1'b0;  // held low across the next frame
    @(posedge clk_28);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    int i;
    int kind;
    int count;
    logic [31:0] rnd;
    kbd_mouse_type_t km_type;
    clk_28      = 1'b0;
    reset       = 1'b1;
    SPI_SCK     = 1'b0;
    SPI_DI      = 1'b0;
    CONF_DATA0  = 1'b1;  // deselected
    SPI_SS2     = 1'b1;
    SPI_SS3     = 1'b1;
    key_ack     = 1'b0;
    cycles      = 0;
    exp_joya    = '0;
    exp_joyb    = '0;
    exp_buttons = '0;
    exp_mouse_x = '0;
    exp_mouse_y = '0;
    void'($urandom(SEED));  // one seed for the whole run
    repeat (5) @(posedge clk_28);
    reset <= 1'b0;
    clock_enable_test();

    // overfill the key fifo in one frame
    frame_buf[0] = CMD_KBD_MOUSE;
    frame_buf[1] = {6'h00, KM_KEYCODE};
    for (i = 2; i < KEY_DEPTH + 4; i++) frame_buf[i] = spi_byte_t'($urandom);
    frame_len = KEY_DEPTH + 4;
    send_frame();
    check_outputs();
    queue_keys(2);
    ack_stretch();

    for (n = 0; n < NUM_FRAMES; n++) begin
      kind = $urandom_range(0, 6);
      rnd  = $urandom;
      frame_buf[1] = rnd[7:0];
      frame_len    = 2;
      case (kind)
        0: begin
          frame_buf[0] = CMD_JOY0;
          exp_joya     = rnd[5:0];
        end
        1: begin
          frame_buf[0] = CMD_JOY1;
          exp_joyb     = rnd[5:0];
        end
        2: begin
          frame_buf[0] = CMD_MOUSE_BTN;
          exp_buttons  = rnd[2:0];
        end
        3: begin
          frame_buf[0] = spi_byte_t'($urandom);
          while (frame_buf[0] inside {CMD_JOY0, CMD_JOY1, CMD_KBD_MOUSE, CMD_MOUSE_BTN})
            frame_buf[0] = spi_byte_t'($urandom);  // unknown command only
          frame_len = $urandom_range(1, 4);
        end
        default: begin
          km_type = (kind == 4) ? KM_MOUSE_X : (kind == 5) ? KM_MOUSE_Y : KM_KEYCODE;
          count   = (kind == 6) ? $urandom_range(1, KEY_DEPTH + 2) : $urandom_range(1, 3);
          frame_buf[0] = CMD_KBD_MOUSE;
          frame_buf[1] = {rnd[7:2], km_type};  // upper bits are don't care
          for (i = 2; i < count + 2; i++) begin
            frame_buf[i] = spi_byte_t'($urandom);
            if (kind == 4) exp_mouse_x = exp_mouse_x + frame_buf[i];  // wraps at 256
            if (kind == 5) exp_mouse_y = exp_mouse_y + frame_buf[i];
          end
          frame_len = count + 2;
        end
      endcase
      send_frame();
      check_outputs();
      if (kind == 6) queue_keys(2);
      ack_stretch();
    end

    // drain what is left
    key_ack <= 1'b1;
    while (key_valid) @(posedge clk_28);
    key_ack <= 1'b0;
    @(posedge clk_28);
    compare("codes left in model", 32'(key_model.size()), 32'(0));

    $display("Simulation passed");
    $finish;
  end

endmodule

/* bench/minimig_io_properties.sv */
`timescale 1ns/10ps
// bound assertions on the chipset clock enables and the keycode handshake
module minimig_io_properties (
  input logic                      clk_28,
  input logic                      reset,
  input logic                      clk7_en,
  input logic                      clk7n_en,
  input minimig_io_pkg::eclk_t     eclk,
  input minimig_io_pkg::spi_byte_t key_code,
  input logic                      key_valid,
  input logic                      key_ack
);

  ////////////////////////////////////////////////////////////
  // clock enables
  ////////////////////////////////////////////////////////////

  enables_apart: assert property (@(posedge clk_28) disable iff (reset)
    !(clk7_en && clk7n_en))  // opposite 7 MHz phases
    else $error("clk7_en and clk7n_en high in the same cycle");

  enable_gap: assert property (@(posedge clk_28) disable iff (reset)
    clk7_en |-> !$past(clk7_en, 1) && !$past(clk7_en, 2) && !$past(clk7_en, 3))
    else $error("clk7_en came back in under 4 cycles");

  enable_recur: assert property (@(posedge clk_28) disable iff (reset)
    $past(clk7_en, 4) |-> clk7_en)  // together with the gap, period is exactly 4
    else $error("clk7_en missing 4 cycles after the last one");

  eclk_onehot: assert property (@(posedge clk_28) disable iff (reset)
    $onehot(eclk))
    else $error("eclk ring is not one-hot");

  ////////////////////////////////////////////////////////////
  // keycode handshake
  ////////////////////////////////////////////////////////////

  key_hold: assert property (@(posedge clk_28) disable iff (reset)
    key_valid && !key_ack |=> $stable(key_code))  // head waits for ack
    else $error("key_code changed while waiting for key_ack");

endmodule

// timing block, no key path there
bind amiga_clk_en minimig_io_properties clk_en_props_i (
  .clk_28    (clk_28),
  .reset     (reset),
  .clk7_en   (clk7_en),
  .clk7n_en  (clk7n_en),
  .eclk      (eclk),
  .key_code  (8'h00),
  .key_valid (1'b0),
  .key_ack   (1'b0)
);

// key port sees only the posedge enable
bind kbd_mouse_port minimig_io_properties key_port_props_i (
  .clk_28    (clk_28),
  .reset     (reset),
  .clk7_en   (clk7_en),
  .clk7n_en  (1'b0),
  .eclk      (10'd1),
  .key_code  (key_code),
  .key_valid (key_valid),
  .key_ack   (key_ack)
);

/* hdl/minimig_io_top.sv */
`timescale 1ns/10ps
// minimig io slice of the fpga top
// clock enables, user_io spi link and keyboard/mouse port in the 28 MHz domain
module minimig_io_top #(
  parameter minimig_io_pkg::spi_byte_t CORE_TYPE = 8'hA1,  // minimig core id
  parameter int KEY_FIFO_DEPTH = 4
) (
  input  logic                       clk_28,
  input  logic                       reset,
  // spi link from the control processor
  input  logic                       SPI_SCK,
  input  logic                       SPI_DI,
  input  logic                       CONF_DATA0,     // user_io select, active low
  input  logic                       SPI_SS2,        // fpga select
  input  logic                       SPI_SS3,        // osd select
  output logic                       SPI_DO,
  // chipset inputs
  output minimig_io_pkg::joy_t       joya,
  output minimig_io_pkg::joy_t       joyb,
  output logic [2:0]                 mouse_buttons,
  output minimig_io_pkg::mouse_dat_t mouse_dat,
  output minimig_io_pkg::spi_byte_t  key_code,
  output logic                       key_valid,
  input  logic                       key_ack,
  // chipset timing
  output logic                       clk7_en,
  output logic                       cck,
  output minimig_io_pkg::eclk_t      eclk
);

  import minimig_io_pkg::*;

  logic            user_io_sdo;
  logic            minimig_sdo;       // data out of the absent core
  spi_byte_t       kbd_mouse_data;
  kbd_mouse_type_t kbd_mouse_type;
  logic            kbd_mouse_strobe;

  ////////////////////////////////////////////////////////////
  // spi data-out mux
  ////////////////////////////////////////////////////////////

  assign minimig_sdo = 1'b0;  // no core behind ss2/ss3
  // user_io while selected, else the core
  assign SPI_DO = ~CONF_DATA0 ? user_io_sdo : minimig_sdo;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  amiga_clk_en amiga_clk_en_i (
    .clk_28   (clk_28),
    .reset    (reset),
    .clk7_en  (clk7_en),
    .clk7n_en (),          // chipset phases unused in this slice
    .c1       (),
    .c3       (),
    .cck      (cck),
    .eclk     (eclk)
  );

  user_io #(
    .CORE_TYPE (CORE_TYPE)
  ) user_io_i (
    .clk_28           (clk_28),
    .reset            (reset),
    .spi_sck          (SPI_SCK),
    .spi_ss_io        (CONF_DATA0),
    .spi_mosi         (SPI_DI),
    .spi_miso         (user_io_sdo),
    .joy0             (joya),
    .joy1             (joyb),
    .mouse_buttons    (mouse_buttons),
    .kbd_mouse_data   (kbd_mouse_data),
    .kbd_mouse_type   (kbd_mouse_type),
    .kbd_mouse_strobe (kbd_mouse_strobe)
  );

  kbd_mouse_port #(
    .KEY_FIFO_DEPTH (KEY_FIFO_DEPTH)
  ) kbd_mouse_port_i (
    .clk_28           (clk_28),
    .reset            (reset),
    .clk7_en          (clk7_en),      // updates land on the 7 MHz edge
    .kbd_mouse_data   (kbd_mouse_data),
    .kbd_mouse_type   (kbd_mouse_type),
    .kbd_mouse_strobe (kbd_mouse_strobe),
    .mouse_dat        (mouse_dat),
    .key_code         (key_code),
    .key_valid        (key_valid),
    .key_ack          (key_ack)
  );

endmodule

/* hdl/kbd_mouse_port.sv */
`timescale 1ns/10ps
// keyboard and mouse port
// accumulates mouse deltas into the counter word, queues keycodes on clk7_en
module kbd_mouse_port #(
  parameter int KEY_FIFO_DEPTH = 4  // power of two, 2 or more
) (
  input  logic                            clk_28,
  input  logic                            reset,
  input  logic                            clk7_en,
  input  minimig_io_pkg::spi_byte_t       kbd_mouse_data,
  input  minimig_io_pkg::kbd_mouse_type_t kbd_mouse_type,
  input  logic                            kbd_mouse_strobe,
  output minimig_io_pkg::mouse_dat_t      mouse_dat,   // {y, x}
  output minimig_io_pkg::spi_byte_t       key_code,    // fifo head
  output logic                            key_valid,
  input  logic                            key_ack
);

  import minimig_io_pkg::*;

  localparam int PTR_W = (KEY_FIFO_DEPTH > 1) ? $clog2(KEY_FIFO_DEPTH) : 1;
  localparam logic [PTR_W:0] CNT_FULL = (PTR_W + 1)'(KEY_FIFO_DEPTH);

  logic            pend_valid;  // strobe waiting for clk7_en
  spi_byte_t       pend_data;
  kbd_mouse_type_t pend_type;
  logic            apply;
  logic            push;
  logic            pop;
  mouse_cnt_t      mouse_x;
  mouse_cnt_t      mouse_y;
  spi_byte_t       key_mem [KEY_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   key_cnt;     // fill level

  ////////////////////////////////////////////////////////////
  // pending strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      pend_valid <= 1'b0;
    end else if (kbd_mouse_strobe) begin
      pend_valid <= 1'b1;  // new strobe wins over the clear
    end else if (clk7_en) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_28) begin
    if (kbd_mouse_strobe) begin
      pend_data <= kbd_mouse_data;
      pend_type <= kbd_mouse_type;
    end
  end

  assign apply = clk7_en & pend_valid;
  // full check on the level before any pop, so a full fifo drops the code
  assign push  = apply & (pend_type == KM_KEYCODE) & (key_cnt != CNT_FULL);
  assign pop   = key_valid & key_ack;

  ////////////////////////////////////////////////////////////
  // mouse counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      mouse_x <= '0;
      mouse_y <= '0;
    end else if (apply) begin
      // signed delta, 8-bit add wraps modulo 256
      if (pend_type == KM_MOUSE_X) mouse_x <= mouse_x + pend_data;
      if (pend_type == KM_MOUSE_Y) mouse_y <= mouse_y + pend_data;
    end
  end

  assign mouse_dat = {mouse_y, mouse_x};

  ////////////////////////////////////////////////////////////
  // keycode fifo
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      key_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   key_cnt <= key_cnt + 1'b1;
        2'b01:   key_cnt <= key_cnt - 1'b1;
        default: key_cnt <= key_cnt;  // none, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_28) begin
    if (push) begin
      key_mem[wr_ptr] <= pend_data;
    end
  end

  assign key_valid = (key_cnt != '0);
  assign key_code  = key_mem[rd_ptr];

endmodule

/* hdl/user_io.sv */
`timescale 1ns/10ps
// user_io spi slave for the control processor link
// decodes joystick, button and keyboard/mouse frames, answers with the core id
module user_io #(
  parameter minimig_io_pkg::spi_byte_t CORE_TYPE = 8'hA1  // core id sent back
) (
  input  logic                            clk_28,
  input  logic                            reset,
  input  logic                            spi_sck,           // mode 0 clock
  input  logic                            spi_ss_io,         // select, active low
  input  logic                            spi_mosi,
  output logic                            spi_miso,
  output minimig_io_pkg::joy_t            joy0,
  output minimig_io_pkg::joy_t            joy1,
  output logic [2:0]                      mouse_buttons,
  output minimig_io_pkg::spi_byte_t       kbd_mouse_data,
  output minimig_io_pkg::kbd_mouse_type_t kbd_mouse_type,
  output logic                            kbd_mouse_strobe   // one cycle pulse
);

  import minimig_io_pkg::*;

  logic [1:0]     sck_sync;   // 2-ff synchronisers
  logic [1:0]     mosi_sync;
  logic [1:0]     ss_sync;
  logic           sck_q;      // previous synced sck
  logic           sck_rise;
  logic           sck_fall;
  logic           ss_idle;    // select released
  logic [2:0]     bit_cnt;    // bit within byte
  logic [6:0]     rx_sreg;    // first 7 bits of a byte
  spi_byte_t      rx_byte;    // byte including current bit
  logic           byte_done;
  spi_byte_t      tx_sreg;
  user_io_state_t state;

  ////////////////////////////////////////////////////////////
  // pin synchronisers and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      sck_sync  <= 2'b00;
      mosi_sync <= 2'b00;
      ss_sync   <= 2'b11;  // deselected
      sck_q     <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], spi_sck};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      ss_sync   <= {ss_sync[0], spi_ss_io};
      sck_q     <= sck_sync[1];
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_q;
  assign sck_fall  = ~sck_sync[1] & sck_q;
  assign ss_idle   = ss_sync[1];
  assign rx_byte   = {rx_sreg, mosi_sync[1]};  // mosi aligned with sck by equal sync depth
  assign byte_done = sck_rise & (bit_cnt == 3'd7);

  ////////////////////////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset || ss_idle) begin
      bit_cnt <= 3'd0;  // realign on every frame
    end else if (sck_rise) begin
      bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk_28) begin
    if (sck_rise) begin
      rx_sreg <= rx_byte[6:0];
    end
  end

  // id preloaded while deselected so bit 7 is out before the first rise
  always_ff @(posedge clk_28) begin
    if (reset || ss_idle) begin
      tx_sreg <= CORE_TYPE;
    end else if (sck_fall) begin
      tx_sreg <= {tx_sreg[6:0], 1'b0};  // zeros after the command byte
    end
  end

  assign spi_miso = tx_sreg[7];

  ////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      state            <= IDLE_CMD;
      joy0             <= '0;
      joy1             <= '0;
      mouse_buttons    <= 3'd0;
      kbd_mouse_strobe <= 1'b0;
    end else begin
      kbd_mouse_strobe <= 1'b0;
      if (ss_idle) begin
        state <= IDLE_CMD;  // frame over
      end else if (byte_done) begin
        case (state)
          IDLE_CMD: begin
            case (rx_byte)
              CMD_JOY0:      state <= JOY0_DATA;
              CMD_JOY1:      state <= JOY1_DATA;
              CMD_KBD_MOUSE: state <= KM_TYPE;
              CMD_MOUSE_BTN: state <= BTN_DATA;
              default:       state <= IGNORE;  // unknown command
            endcase
          end
          JOY0_DATA: begin
            joy0  <= rx_byte[5:0];
            state <= IGNORE;
          end
          JOY1_DATA: begin
            joy1  <= rx_byte[5:0];
            state <= IGNORE;
          end
          BTN_DATA: begin
            mouse_buttons <= rx_byte[2:0];
            state         <= IGNORE;
          end
          KM_TYPE:  state <= KM_DATA;
          KM_DATA:  kbd_mouse_strobe <= 1'b1;  // one per data byte
          default:  state <= IGNORE;
        endcase
      end
    end
  end

  // strobe payload, valid alongside kbd_mouse_strobe
  always_ff @(posedge clk_28) begin
    if (byte_done && (state == KM_TYPE)) begin
      kbd_mouse_type <= rx_byte[1:0];
    end
    if (byte_done && (state == KM_DATA)) begin
      kbd_mouse_data <= rx_byte;
    end
  end

endmodule

/* hdl/amiga_clk_en.sv */
`timescale 1ns/10ps
// amiga chipset clock enables in the 28 MHz domain
// 7 MHz enables, c1/c3 phases, colour clock and e-clock ring, no pll
module amiga_clk_en (
  input  logic                  clk_28,    // 28 MHz chipset clock
  input  logic                  reset,     // sync, active high
  output logic                  clk7_en,   // 7 MHz posedge enable
  output logic                  clk7n_en,  // 7 MHz negedge enable
  output logic                  c1,        // in step with 7 MHz clock
  output logic                  c3,        // c1 delayed by 90 degrees
  output logic                  cck,       // colour clock, 3.5 MHz
  output minimig_io_pkg::eclk_t eclk       // e-clock ring, 0.7 MHz
);

  import minimig_io_pkg::*;

  logic [1:0] phase;  // 28 MHz cycle within one 7 MHz period

  ////////////////////////////////////////////////////////////
  // phase counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;  // free running
    end
  end

  // all enables decoded from the one counter so every block
  // in this domain sees the same 7 MHz phase
  assign clk7_en  = (phase == 2'd3);
  assign clk7n_en = (phase == 2'd1);
  assign c1       = ~phase[1];            // phases 0,1
  assign c3       = phase[1] ^ phase[0];  // phases 1,2

  ////////////////////////////////////////////////////////////
  // colour clock and e-clock
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      cck  <= 1'b0;
      eclk <= eclk_t'(1);  // ring starts at bit 0
    end else if (clk7_en) begin
      cck  <= ~cck;                    // 8 clk_28 period
      eclk <= {eclk[8:0], eclk[9]};    // one step per 7 MHz cycle
    end
  end

endmodule

/* hdl/minimig_io_pkg.sv */
// minimig io shared definitions
// widths, control processor command codes, strobe types and user_io states
package minimig_io_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [5:0]  joy_t;             // fire2,fire,up,down,left,right
  typedef logic [7:0]  spi_byte_t;        // one spi byte, msb first on the wire
  typedef logic [7:0]  mouse_cnt_t;       // one mouse axis counter
  typedef logic [15:0] mouse_dat_t;       // {y counter, x counter}
  typedef logic [9:0]  eclk_t;            // e-clock one-hot ring
  typedef logic [1:0]  kbd_mouse_type_t;  // strobe type

  ////////////////////////////////////////////////////////////
  // command codes, first byte of every frame
  ////////////////////////////////////////////////////////////

  localparam spi_byte_t CMD_JOY0      = 8'h01;  // joystick a state
  localparam spi_byte_t CMD_JOY1      = 8'h02;  // joystick b state
  localparam spi_byte_t CMD_KBD_MOUSE = 8'h04;  // type byte, then data bytes
  localparam spi_byte_t CMD_MOUSE_BTN = 8'h05;  // mouse buttons

  // strobe types carried with kbd_mouse_strobe
  localparam kbd_mouse_type_t KM_MOUSE_X = 2'd0;  // signed x delta
  localparam kbd_mouse_type_t KM_MOUSE_Y = 2'd1;  // signed y delta
  localparam kbd_mouse_type_t KM_KEYCODE = 2'd2;  // amiga keycode
  localparam kbd_mouse_type_t KM_UNUSED  = 2'd3;  // dropped by the port

  ////////////////////////////////////////////////////////////
  // user_io frame fsm
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE_CMD,   // waiting for command byte
    JOY0_DATA,  // next byte is joystick a
    JOY1_DATA,  // next byte is joystick b
    KM_TYPE,    // next byte selects strobe type
    KM_DATA,    // every byte is one strobe
    BTN_DATA,   // next byte is mouse buttons
    IGNORE      // rest of frame discarded
  } user_io_state_t;

endpackage
